// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_usb_aon_wake
FILELIST ?= compile.f
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
usb_aon_pkg.sv
usb_aon_evt_if.sv
usb_aon_filter.sv
usb_aon_wake_detect.sv
usb_aon_evt_fifo.sv
usb_aon_wb_regs.sv
usb_aon_wake_top.sv
usb_aon_wake_properties.sv
tb_clkgen.sv
tb_usb_aon_wake.sv

// File: tb_clkgen.sv
/*
  Testbench clock and reset source.
  Reset is released on a falling edge after reset_cycles_p rising edges.
*/
module tb_clkgen #(
  parameter int unsigned period_p       = 8,
  parameter int unsigned reset_cycles_p = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (2 * reset_cycles_p) #(period_p / 2) clk_o = ~clk_o;
    rst_no = 1'b1;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

endmodule

// File: tb_usb_aon_wake.sv
/*
  Random testbench for the AON wake path, seeded once for repeatable runs.
  Lines idle at the pull-up levels, and pull-up pairs are never both zero when idle.
*/
module tb_usb_aon_wake;

  localparam int unsigned DataW = usb_aon_pkg::DataW;
  localparam int Depth = usb_aon_pkg::FifoDepth;
  localparam int LevelW = usb_aon_pkg::FifoLevelW;
  // Six tests, each well under 400 cycles, plus a margin
  localparam int CycleLimit = 6 * 400 + 500;

  logic clk, rst_n, dp, dn, sense, core_dp, core_dn, cyc, stb, we, ack;
  logic pu_dp, pu_dn, wake_req;
  logic [1:0] adr;
  logic [DataW-1:0] wdat, rdat, q;
  // Reference model state
  logic m_active, m_not_idle, m_reset, m_sense, m_ovf;
  logic [1:0] m_core, m_hold, v;
  int m_queued, cycles, tests, failed, errors, test_errors, g;
  int assert_fails;
  bit m_pend[5];
  int exp_cnt[5];
  string test_name;

  tb_clkgen #(.period_p(8), .reset_cycles_p(8)) u_clkgen (.clk_o(clk), .rst_no(rst_n));

  usb_aon_wake_top dut_i (
    .clk_aon_i(clk), .rst_aon_ni(rst_n), .usb_dp_i(dp), .usb_dn_i(dn), .usb_sense_i(sense),
    .usbdev_dppullup_en_i(core_dp), .usbdev_dnpullup_en_i(core_dn),
    .wb_cyc_i(cyc), .wb_stb_i(stb), .wb_we_i(we), .wb_adr_i(adr), .wb_dat_i(wdat),
    .wb_dat_o(rdat), .wb_ack_o(ack), .usb_dppullup_en_o(pu_dp), .usb_dnpullup_en_o(pu_dn),
    .wake_req_o(wake_req)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic compare_status(input logic [DataW-1:0] exp, input logic [DataW-1:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic compare_kind(input usb_aon_pkg::evt_kind_e exp,
                              input usb_aon_pkg::evt_kind_e act);
    if (exp !== act) begin
      $display("ERR %s expected %s actual %s", test_name, exp.name(), act.name());
      test_errors++;
    end
  endtask

  task automatic compare_pullups(input logic [1:0] exp, input logic [1:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %b actual %b", test_name, exp, act);
      test_errors++;
    end
  endtask

  // Wake request pin of the top level
  task automatic compare_wake_req(input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %s expected %b actual %b", test_name, exp, act);
      test_errors++;
    end
  endtask

  // One classic cycle, request held through the ack cycle
  task automatic wb_access(input logic w, input logic [1:0] a, input logic [DataW-1:0] d);
    int n;
    n = 0;
    @(negedge clk);
    {cyc, stb, we, adr, wdat} = {1'b1, 1'b1, w, a, d};
    @(negedge clk);
    while (!ack && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!ack) begin
      $display("%s: the Wishbone slave never answered", test_name);
      test_errors++;
    end
    q = rdat;
    @(negedge clk);
    {cyc, stb, we} = 3'b000;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Expected status word from the model, then the clear-on-read of overflow
  task automatic check_status();
    logic [DataW-1:0] s;
    s = '0;
    s[usb_aon_pkg::StatusActiveBit]    = m_active;
    s[usb_aon_pkg::StatusWakeReqBit]   = m_not_idle | m_reset | m_sense;
    s[usb_aon_pkg::StatusNotIdleBit]   = m_not_idle;
    s[usb_aon_pkg::StatusBusResetBit]  = m_reset;
    s[usb_aon_pkg::StatusSenseLostBit] = m_sense;
    s[usb_aon_pkg::StatusOverflowBit]  = m_ovf;
    s[usb_aon_pkg::StatusLevelLsb +: usb_aon_pkg::FifoLevelW] =
      LevelW'((m_queued > Depth) ? Depth : m_queued);
    wb_access(1'b0, usb_aon_pkg::RegStatus, '0);
    compare_status(s, q);
    compare_wake_req(s[usb_aon_pkg::StatusWakeReqBit], wake_req);
    // A stalled detector sets overflow again straight away
    if (m_queued <= Depth) m_ovf = 1'b0;
  endtask

  // A full FIFO parks the kind as pending, and a second rise merges into it
  task automatic note_event(input int k);
    if (m_queued >= Depth && m_pend[k]) begin
      m_ovf = 1'b1;
    end else begin
      if (m_queued >= Depth) begin
        m_pend[k] = 1'b1;
        m_ovf = 1'b1;
      end
      m_queued++;
      exp_cnt[k]++;
    end
  endtask

  // Pop until empty and compare the drained kinds as sorted lists
  task automatic drain_events();
    usb_aon_pkg::evt_kind_e exp_q[$];
    usb_aon_pkg::evt_kind_e got_q[$];
    int got[5];
    for (int i = 0; i < 5; i++) got[i] = 0;
    for (int i = 0; i < 2 * Depth; i++) begin
      wb_access(1'b0, usb_aon_pkg::RegEvent, '0);
      if (!q[usb_aon_pkg::EvtValidBit]) break;
      got[q[usb_aon_pkg::EvtKindLsb +: 3]]++;
      m_queued--;
    end
    for (int k = 0; k < 5; k++) begin
      repeat (exp_cnt[k]) exp_q.push_back(usb_aon_pkg::evt_kind_e'(k));
      repeat (got[k]) got_q.push_back(usb_aon_pkg::evt_kind_e'(k));
      exp_cnt[k] = 0;
      m_pend[k] = 1'b0;
    end
    if (exp_q.size() != got_q.size()) begin
      $display("%s: drained %0d events but %0d were expected", test_name, got_q.size(),
               exp_q.size());
      test_errors++;
    end
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      compare_kind(exp_q[i], got_q[i]);
    end
    m_queued = 0;
  endtask

  // Core pull-ups from the model, and lines resting at the pull-up outputs
  task automatic drive_idle();
    {core_dp, core_dn} = m_core;
    {dp, dn} = m_active ? m_hold : m_core;
    sense = 1'b1;
  endtask

  // Glitch or condition of n cycles, then back to idle
  task automatic pulse_lines(input logic [1:0] lines, input logic s, input int n);
    @(negedge clk);
    {dp, dn} = lines;
    sense = s;
    repeat (n) @(negedge clk);
    drive_idle();
  endtask

  task automatic write_ctrl(input int bit_pos);
    wb_access(1'b1, usb_aon_pkg::RegCtrl, DataW'(1) << bit_pos);
    m_active = (bit_pos == usb_aon_pkg::CtrlSuspendBit);
    if (m_active) begin
      m_hold = m_core;
      note_event(usb_aon_pkg::EvtSuspend);
    end else begin
      {m_not_idle, m_reset, m_sense} = 3'b000;
      note_event(usb_aon_pkg::EvtWakeAck);
    end
  endtask

  task automatic finish_test();
    tests++;
    errors += test_errors;
    if (test_errors != 0) failed++;
    $display("test %s: %s (%0d errors)", test_name, (test_errors == 0) ? "ok" : "bad",
             test_errors);
    test_errors = 0;
  endtask

  initial begin
    void'($urandom(56));
    {cyc, stb, we, adr, wdat} = '0;
    {dp, dn, sense, core_dp, core_dn} = 5'b11111;
    {m_active, m_not_idle, m_reset, m_sense, m_ovf} = '0;
    m_core = 2'b11;
    m_hold = 2'b00;
    {m_queued, cycles, tests, failed, errors, test_errors} = '0;
    assert_fails = 0;
    for (int k = 0; k < 5; k++) exp_cnt[k] = 0;
    @(posedge rst_n);
    wait_cycles(2);

    test_name = "reset";
    check_status();
    drain_events();
    repeat (4) begin
      m_core = 2'($urandom_range(1, 3));
      @(negedge clk);
      drive_idle();
      @(negedge clk);
      compare_pullups(m_core, {pu_dp, pu_dn});
    end
    wait_cycles(10);
    finish_test();

    test_name = "suspend";
    write_ctrl(usb_aon_pkg::CtrlSuspendBit);
    wait_cycles(4);
    check_status();
    drain_events();
    repeat (8) begin
      m_core = 2'($urandom_range(0, 3));
      @(negedge clk);
      drive_idle();
      @(negedge clk);
      compare_pullups(m_hold, {pu_dp, pu_dn});
    end
    repeat (6) begin
      g = $urandom_range(1, 2);
      v = m_hold[1] ? (m_hold[0] ? 2'b01 : 2'b11) : {1'b1, m_hold[0]};
      case ($urandom_range(0, 2))
        0: pulse_lines(v, 1'b1, g);
        1: pulse_lines(2'b00, 1'b1, g);
        default: pulse_lines(m_hold, 1'b0, g);
      endcase
      wait_cycles($urandom_range(4, 8));
    end
    wait_cycles(10);
    check_status();
    drain_events();
    finish_test();

    test_name = "resume";
    // Raise a line that is low, or drop D+ when both are high, so SE0 never appears
    v = m_hold[1] ? (m_hold[0] ? 2'b01 : 2'b11) : {1'b1, m_hold[0]};
    pulse_lines(v, 1'b1, $urandom_range(8, 14));
    note_event(usb_aon_pkg::EvtNotIdle);
    m_not_idle = 1'b1;
    wait_cycles(12);
    check_status();
    drain_events();
    finish_test();

    test_name = "reset_and_sense";
    pulse_lines(2'b00, 1'b1, $urandom_range(6, 12));
    note_event(usb_aon_pkg::EvtBusReset);
    m_reset = 1'b1;
    wait_cycles(12);
    pulse_lines(m_hold, 1'b0, $urandom_range(6, 12));
    note_event(usb_aon_pkg::EvtSenseLost);
    m_sense = 1'b1;
    wait_cycles(12);
    check_status();
    drain_events();
    finish_test();

    test_name = "wake_ack";
    m_core = 2'($urandom_range(1, 3));
    @(negedge clk);
    drive_idle();
    write_ctrl(usb_aon_pkg::CtrlWakeAckBit);
    drive_idle();
    wait_cycles(10);
    compare_pullups(m_core, {pu_dp, pu_dn});
    check_status();
    drain_events();
    finish_test();

    test_name = "overflow";
    repeat (6) begin
      write_ctrl(usb_aon_pkg::CtrlSuspendBit);
      wait_cycles($urandom_range(4, 8));
      write_ctrl(usb_aon_pkg::CtrlWakeAckBit);
      wait_cycles($urandom_range(4, 8));
    end
    check_status();
    drain_events();
    check_status();
    check_status();
    finish_test();

    assert_fails = dut_i.u_wb_regs.u_bus_props.fail_cnt +
                   dut_i.u_wake_detect.u_hold_props.fail_cnt;
    if (assert_fails != 0) begin
      $display("Bound assertions failed %0d times during the run", assert_fails);
    end
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", tests, failed,
             errors, assert_fails);
    if (failed == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: usb_aon_evt_fifo.sv
/*
  Event FIFO between the wake detector and the register block.
  Depth must be a power of two, the pointers wrap without compare logic.
  Overflow marks that the detector was held off by a full FIFO.
*/
module usb_aon_evt_fifo (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  usb_aon_evt_if.consumer push_i,
  usb_aon_evt_if.producer pop_o,
  input  logic clear_ovf_i,
  output logic overflow_o
);

  localparam int unsigned Depth  = usb_aon_pkg::FifoDepth;
  localparam int unsigned PtrW   = usb_aon_pkg::FifoPtrW;
  localparam int unsigned LevelW = usb_aon_pkg::FifoLevelW;

  usb_aon_pkg::evt_t mem_q [Depth];
  logic [PtrW-1:0]   wr_ptr_q, rd_ptr_q;
  logic [LevelW-1:0] count_q;
  logic              push_xfer, pop_xfer;
  logic              overflow_q;

  // Accept pushes only while there is room
  assign push_i.ready = (count_q != LevelW'(Depth));
  assign push_xfer    = push_i.valid & push_i.ready;
  assign pop_xfer     = pop_o.valid & pop_o.ready;

  // Head of the queue and its occupancy
  assign pop_o.valid = (count_q != '0);
  assign pop_o.evt   = mem_q[rd_ptr_q];
  assign pop_o.level = count_q;

  always_ff @(posedge clk_aon_i) begin
    if (push_xfer) begin
      mem_q[wr_ptr_q] <= push_i.evt;
    end
  end

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push_xfer) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_xfer) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Level moves only when exactly one side transfers
      if (push_xfer && !pop_xfer) begin
        count_q <= count_q + 1'b1;
      end else if (pop_xfer && !push_xfer) begin
        count_q <= count_q - 1'b1;
      end
      // A new stall wins over a clear in the same cycle
      overflow_q <= (overflow_q & ~clear_ovf_i) | (push_i.valid & ~push_i.ready);
    end
  end

  assign overflow_o = overflow_q;

endmodule

// File: usb_aon_evt_if.sv
/*
  Valid/ready event stream with a level count travelling alongside.
  A transfer happens on a rising edge with valid and ready both high.
  The payload must not change while valid is high and ready is low.
*/
interface usb_aon_evt_if;

  // Handshake pair
  logic valid;
  logic ready;

  // Event payload offered by the producer
  usb_aon_pkg::evt_t evt;

  // Occupancy seen on the producer side
  logic [usb_aon_pkg::FifoLevelW-1:0] level;

  // The side that offers events
  modport producer (output valid, output evt, output level, input ready);

  // The side that accepts events
  modport consumer (input valid, input evt, input level, output ready);

endinterface

// File: usb_aon_filter.sv
/*
  Two-flop synchronizer followed by a stability filter.
  The output follows the input 2 + cycles_p clocks after a clean change.
  Pulses shorter than cycles_p samples never reach the output.
*/
module usb_aon_filter #(
  parameter int unsigned cycles_p = 4
) (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  input  logic filter_i,
  output logic filter_o
);

  localparam int unsigned CntW = $clog2(cycles_p + 1);

  logic [1:0]      sync_q;
  logic            last_q;
  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;

  // Count consecutive equal samples of the synchronized input, saturating at cycles_p
  always_comb begin
    if (sync_q[1] != last_q) begin
      cnt_d = CntW'(1);
    end else if (cnt_q == CntW'(cycles_p)) begin
      cnt_d = cnt_q;
    end else begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      sync_q   <= 2'b00;
      last_q   <= 1'b0;
      cnt_q    <= '0;
      filter_o <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], filter_i};
      last_q <= sync_q[1];
      cnt_q  <= cnt_d;
      // The synchronized value is accepted once it has held long enough
      if (cnt_d == CntW'(cycles_p)) begin
        filter_o <= sync_q[1];
      end
    end
  end

endmodule

// File: usb_aon_pkg.sv
/*
  Shared types and constants for the always-on USB wake detector.
  Event kinds are listed in emit priority order, lowest value first.
  The FIFO depth must stay a power of two so the pointers wrap naturally.
*/
package usb_aon_pkg;

  // Wishbone data and address widths
  localparam int unsigned DataW = 32;
  localparam int unsigned AdrW  = 2;

  // Event kinds, the lowest encoding is emitted first
  typedef enum logic [2:0] {
    EvtSuspend   = 3'd0,
    EvtNotIdle   = 3'd1,
    EvtBusReset  = 3'd2,
    EvtSenseLost = 3'd3,
    EvtWakeAck   = 3'd4
  } evt_kind_e;

  localparam int unsigned NumKinds = 5;
  localparam int unsigned StampW   = 16;

  // One queued event, 19 bits in total
  typedef struct packed {
    evt_kind_e           kind;
    logic [StampW-1:0]   stamp;
  } evt_t;

  // Glitch filter lengths in AON clock samples
  localparam int unsigned NotIdleCycles = 4;
  localparam int unsigned EdgeCycles    = 3;

  // Event FIFO geometry
  localparam int unsigned FifoDepth  = 8;
  localparam int unsigned FifoLevelW = 4;
  localparam int unsigned FifoPtrW   = 3;

  // Register word addresses
  localparam logic [AdrW-1:0] RegCtrl   = 2'd0;
  localparam logic [AdrW-1:0] RegStatus = 2'd1;
  localparam logic [AdrW-1:0] RegEvent  = 2'd2;

  // Control register, write-one pulse bits
  localparam int unsigned CtrlSuspendBit = 0;
  localparam int unsigned CtrlWakeAckBit = 1;

  // Status register layout
  localparam int unsigned StatusActiveBit    = 0;
  localparam int unsigned StatusWakeReqBit   = 1;
  localparam int unsigned StatusNotIdleBit   = 2;
  localparam int unsigned StatusBusResetBit  = 3;
  localparam int unsigned StatusSenseLostBit = 4;
  localparam int unsigned StatusOverflowBit  = 5;
  localparam int unsigned StatusLevelLsb     = 8;

  // Event register layout, the stamp sits in the low bits
  localparam int unsigned EvtValidBit = 31;
  localparam int unsigned EvtKindLsb  = 16;

endpackage

// File: usb_aon_wake_detect.sv
/*
  Always-on wake detector: suspend state, sticky wake causes and pull-up hold.
  Suspend request and wake acknowledge must already be single AON-cycle pulses.
  Each condition is queued as one pending bit per kind, so repeats merge.
  The 16-bit stamp counter wraps silently.
*/
module usb_aon_wake_detect (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  input  logic usb_dp_i,
  input  logic usb_dn_i,
  input  logic usb_sense_i,
  input  logic usbdev_dppullup_en_i,
  input  logic usbdev_dnpullup_en_i,
  input  logic suspend_req_i,
  input  logic wake_ack_i,
  output logic usb_dppullup_en_o,
  output logic usb_dnpullup_en_o,
  output logic wake_req_o,
  output logic active_o,
  output logic bus_not_idle_o,
  output logic bus_reset_o,
  output logic sense_lost_o,
  usb_aon_evt_if.producer evt_o
);

  localparam int unsigned NumKinds = usb_aon_pkg::NumKinds;
  localparam int unsigned StampW   = usb_aon_pkg::StampW;

  logic active_d, active_q;
  logic not_idle_async, se0_async, sense_lost_async;
  logic event_not_idle, event_bus_reset, event_sense_lost;
  logic not_idle_d, not_idle_q, bus_reset_d, bus_reset_q;
  logic sense_lost_d, sense_lost_q, wake_req_d, wake_req_q;
  logic [1:0] pullup_sync1_q, pullup_sync2_q, pullup_hold_q;
  logic [StampW-1:0] stamp_cnt_q;
  logic [StampW-1:0] stamp_q [NumKinds];
  logic [NumKinds-1:0] rise_vec, clear_vec, pending_q;
  logic [2:0] pick_idx, sel_idx, lock_idx_q;
  logic lock_q, xfer;

  // The pull-ups set the idle line state, so any line that disagrees means host activity
  assign not_idle_async   = (usb_dp_i != usb_dppullup_en_o) | (usb_dn_i != usb_dnpullup_en_o);
  assign se0_async        = ~usb_dp_i & ~usb_dn_i;
  assign sense_lost_async = ~usb_sense_i;

  usb_aon_filter #(.cycles_p(usb_aon_pkg::NotIdleCycles)) u_filter_not_idle (
    .clk_aon_i, .rst_aon_ni, .filter_i(not_idle_async), .filter_o(event_not_idle)
  );
  usb_aon_filter #(.cycles_p(usb_aon_pkg::EdgeCycles)) u_filter_se0 (
    .clk_aon_i, .rst_aon_ni, .filter_i(se0_async), .filter_o(event_bus_reset)
  );
  usb_aon_filter #(.cycles_p(usb_aon_pkg::EdgeCycles)) u_filter_sense (
    .clk_aon_i, .rst_aon_ni, .filter_i(sense_lost_async), .filter_o(event_sense_lost)
  );

  // Suspend state, entered on request and left on acknowledge
  assign active_d = active_q ? ~wake_ack_i : suspend_req_i;

  // Sticky causes only collect while active and clear once active has dropped
  assign not_idle_d   = (event_not_idle | not_idle_q) & active_q;
  assign bus_reset_d  = (event_bus_reset | bus_reset_q) & active_q;
  assign sense_lost_d = (event_sense_lost | sense_lost_q) & active_q;
  assign wake_req_d   = (event_not_idle | event_bus_reset | event_sense_lost | wake_req_q) &
                        active_q;

  // Conditions that queue an event, one bit per kind
  always_comb begin
    rise_vec = '0;
    rise_vec[usb_aon_pkg::EvtSuspend]   = active_d & ~active_q;
    rise_vec[usb_aon_pkg::EvtNotIdle]   = not_idle_d & ~not_idle_q;
    rise_vec[usb_aon_pkg::EvtBusReset]  = bus_reset_d & ~bus_reset_q;
    rise_vec[usb_aon_pkg::EvtSenseLost] = sense_lost_d & ~sense_lost_q;
    rise_vec[usb_aon_pkg::EvtWakeAck]   = ~active_d & active_q;
  end

  // Lowest pending kind wins, but a kind already on offer stays until taken
  always_comb begin
    pick_idx = '0;
    for (int i = NumKinds - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        pick_idx = 3'(i);
      end
    end
  end
  assign sel_idx = lock_q ? lock_idx_q : pick_idx;
  assign xfer    = evt_o.valid & evt_o.ready;

  always_comb begin
    clear_vec = '0;
    clear_vec[sel_idx] = xfer;
  end

  assign evt_o.valid      = |pending_q;
  assign evt_o.evt.kind   = usb_aon_pkg::evt_kind_e'(sel_idx);
  assign evt_o.evt.stamp  = stamp_q[sel_idx];

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      active_q       <= 1'b0;
      not_idle_q     <= 1'b0;
      bus_reset_q    <= 1'b0;
      sense_lost_q   <= 1'b0;
      wake_req_q     <= 1'b0;
      pullup_sync1_q <= 2'b00;
      pullup_sync2_q <= 2'b00;
      pullup_hold_q  <= 2'b00;
      stamp_cnt_q    <= '0;
      pending_q      <= '0;
      lock_q         <= 1'b0;
      lock_idx_q     <= '0;
    end else begin
      active_q       <= active_d;
      not_idle_q     <= not_idle_d;
      bus_reset_q    <= bus_reset_d;
      sense_lost_q   <= sense_lost_d;
      wake_req_q     <= wake_req_d;
      pullup_sync1_q <= {usbdev_dppullup_en_i, usbdev_dnpullup_en_i};
      pullup_sync2_q <= pullup_sync1_q;
      // Freeze the synchronized pull-ups for as long as suspend lasts
      if (!active_q) begin
        pullup_hold_q <= pullup_sync2_q;
      end
      stamp_cnt_q <= stamp_cnt_q + 1'b1;
      // A rise in the same cycle as its transfer starts a fresh event
      pending_q   <= (pending_q & ~clear_vec) | rise_vec;
      lock_q      <= evt_o.valid & ~evt_o.ready;
      lock_idx_q  <= sel_idx;
    end
  end

  // Stamps keep the time of the first rise, merged repeats leave them alone
  always_ff @(posedge clk_aon_i) begin
    for (int i = 0; i < NumKinds; i++) begin
      if (rise_vec[i] && (!pending_q[i] || clear_vec[i])) begin
        stamp_q[i] <= stamp_cnt_q;
      end
    end
  end

  assign usb_dppullup_en_o = active_q ? pullup_hold_q[1] : usbdev_dppullup_en_i;
  assign usb_dnpullup_en_o = active_q ? pullup_hold_q[0] : usbdev_dnpullup_en_i;
  assign wake_req_o        = wake_req_q;
  assign active_o          = active_q;
  assign bus_not_idle_o    = not_idle_q;
  assign bus_reset_o       = bus_reset_q;
  assign sense_lost_o      = sense_lost_q;

endmodule

// File: usb_aon_wake_properties.sv
/*
  Concurrent checks bound into the register block and the wake detector.
  Each bound instance enables only the group of checks that fits its target.
*/
module usb_aon_wake_properties (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       check_bus_i,
  input logic       req_i,
  input logic       ack_i,
  input logic       check_hold_i,
  input logic       active_i,
  input logic [1:0] pullup_i
);

  // Number of failed checks in this instance
  int fail_cnt;

  initial begin
    fail_cnt = 0;
  end

  // Ack lasts one cycle and is followed by at least one idle cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) check_bus_i && ack_i |=> !ack_i)
    else begin
      $error("Wishbone ack lasted longer than one cycle");
      fail_cnt++;
    end

  // A fresh request is answered on the next edge
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_bus_i && req_i && !ack_i |=> ack_i)
    else begin
      $error("Wishbone ack did not follow the request");
      fail_cnt++;
    end

  // Ack is held low in reset
  assert property (@(posedge clk_i) check_bus_i && !rst_ni |-> !ack_i)
    else begin
      $error("Wishbone ack high during reset");
      fail_cnt++;
    end

  // Pull-ups stay frozen for as long as suspend lasts
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_hold_i && active_i && $past(active_i) |-> $stable(pullup_i))
    else begin
      $error("Pull-up enables moved while the detector was active");
      fail_cnt++;
    end

endmodule

bind usb_aon_wb_regs usb_aon_wake_properties u_bus_props (
  .clk_i(clk_aon_i), .rst_ni(rst_aon_ni), .check_bus_i(1'b1),
  .req_i(wb_cyc_i & wb_stb_i), .ack_i(wb_ack_o),
  .check_hold_i(1'b0), .active_i(1'b0), .pullup_i(2'b00)
);

bind usb_aon_wake_detect usb_aon_wake_properties u_hold_props (
  .clk_i(clk_aon_i), .rst_ni(rst_aon_ni), .check_bus_i(1'b0), .req_i(1'b0), .ack_i(1'b0),
  .check_hold_i(1'b1), .active_i(active_q), .pullup_i({usb_dppullup_en_o, usb_dnpullup_en_o})
);

// File: usb_aon_wake_top.sv
/*
  Top level of the always-on USB wake path.
  Every input, the Wishbone bus included, must be in the AON clock domain
  except the core pull-up enables, which are synchronized inside.
*/
module usb_aon_wake_top (
  input  logic                          clk_aon_i,
  input  logic                          rst_aon_ni,
  input  logic                          usb_dp_i,
  input  logic                          usb_dn_i,
  input  logic                          usb_sense_i,
  input  logic                          usbdev_dppullup_en_i,
  input  logic                          usbdev_dnpullup_en_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [usb_aon_pkg::AdrW-1:0]  wb_adr_i,
  input  logic [usb_aon_pkg::DataW-1:0] wb_dat_i,
  output logic [usb_aon_pkg::DataW-1:0] wb_dat_o,
  output logic                          wb_ack_o,
  output logic                          usb_dppullup_en_o,
  output logic                          usb_dnpullup_en_o,
  output logic                          wake_req_o
);

  logic suspend_req, wake_ack, clear_ovf, overflow;
  logic active, bus_not_idle, bus_reset, sense_lost;

  // Detector to FIFO, and FIFO to register block
  usb_aon_evt_if evt_push ();
  usb_aon_evt_if evt_pop ();

  usb_aon_wake_detect u_wake_detect (
    .clk_aon_i, .rst_aon_ni,
    .usb_dp_i, .usb_dn_i, .usb_sense_i,
    .usbdev_dppullup_en_i, .usbdev_dnpullup_en_i,
    .suspend_req_i  (suspend_req),
    .wake_ack_i     (wake_ack),
    .usb_dppullup_en_o, .usb_dnpullup_en_o, .wake_req_o,
    .active_o       (active),
    .bus_not_idle_o (bus_not_idle),
    .bus_reset_o    (bus_reset),
    .sense_lost_o   (sense_lost),
    .evt_o          (evt_push.producer)
  );

  usb_aon_evt_fifo u_evt_fifo (
    .clk_aon_i, .rst_aon_ni,
    .push_i      (evt_push.consumer),
    .pop_o       (evt_pop.producer),
    .clear_ovf_i (clear_ovf),
    .overflow_o  (overflow)
  );

  usb_aon_wb_regs u_wb_regs (
    .clk_aon_i, .rst_aon_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .active_i       (active),
    .wake_req_i     (wake_req_o),
    .bus_not_idle_i (bus_not_idle),
    .bus_reset_i    (bus_reset),
    .sense_lost_i   (sense_lost),
    .overflow_i     (overflow),
    .wb_dat_o, .wb_ack_o,
    .suspend_req_o  (suspend_req),
    .wake_ack_o     (wake_ack),
    .clear_ovf_o    (clear_ovf),
    .evt_i          (evt_pop.consumer)
  );

endmodule

// File: usb_aon_wb_regs.sv
/*
  Wishbone classic slave with control, status and event-pop registers.
  Ack comes one cycle after a request and lasts one cycle.
  The master must hold address, data and we steady until ack.
*/
module usb_aon_wb_regs (
  input  logic                          clk_aon_i,
  input  logic                          rst_aon_ni,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [usb_aon_pkg::AdrW-1:0]  wb_adr_i,
  input  logic [usb_aon_pkg::DataW-1:0] wb_dat_i,
  input  logic                          active_i,
  input  logic                          wake_req_i,
  input  logic                          bus_not_idle_i,
  input  logic                          bus_reset_i,
  input  logic                          sense_lost_i,
  input  logic                          overflow_i,
  output logic [usb_aon_pkg::DataW-1:0] wb_dat_o,
  output logic                          wb_ack_o,
  output logic                          suspend_req_o,
  output logic                          wake_ack_o,
  output logic                          clear_ovf_o,
  usb_aon_evt_if.consumer               evt_i
);

  localparam int unsigned DataW = usb_aon_pkg::DataW;

  logic             ack_q;
  logic             req, ack_wr, ack_rd;
  logic [DataW-1:0] status_word, event_word, rd_data;
  logic [DataW-1:0] dat_q;

  assign req    = wb_cyc_i & wb_stb_i;
  assign ack_wr = ack_q & req & wb_we_i;
  assign ack_rd = ack_q & req & ~wb_we_i;

  // Live flags and FIFO level
  always_comb begin
    status_word = '0;
    status_word[usb_aon_pkg::StatusActiveBit]    = active_i;
    status_word[usb_aon_pkg::StatusWakeReqBit]   = wake_req_i;
    status_word[usb_aon_pkg::StatusNotIdleBit]   = bus_not_idle_i;
    status_word[usb_aon_pkg::StatusBusResetBit]  = bus_reset_i;
    status_word[usb_aon_pkg::StatusSenseLostBit] = sense_lost_i;
    status_word[usb_aon_pkg::StatusOverflowBit]  = overflow_i;
    status_word[usb_aon_pkg::StatusLevelLsb +: usb_aon_pkg::FifoLevelW] = evt_i.level;
  end

  // Head of the event FIFO, all zero when it is empty
  always_comb begin
    event_word = '0;
    if (evt_i.valid) begin
      event_word[usb_aon_pkg::EvtValidBit] = 1'b1;
      event_word[usb_aon_pkg::EvtKindLsb +: 3] = evt_i.evt.kind;
      event_word[usb_aon_pkg::StampW-1:0] = evt_i.evt.stamp;
    end
  end

  // Control is write only and reads back as zero
  always_comb begin
    case (wb_adr_i)
      usb_aon_pkg::RegStatus: rd_data = status_word;
      usb_aon_pkg::RegEvent:  rd_data = event_word;
      default:                rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      ack_q <= 1'b0;
    end else begin
      // One ack per request, then at least one idle cycle
      ack_q <= req & ~ack_q;
    end
  end

  // Read data is captured as ack rises and held through the ack cycle
  always_ff @(posedge clk_aon_i) begin
    if (req && !ack_q) begin
      dat_q <= rd_data;
    end
  end

  // Pulses and side effects all fall in the ack cycle
  assign suspend_req_o = ack_wr & (wb_adr_i == usb_aon_pkg::RegCtrl) &
                         wb_dat_i[usb_aon_pkg::CtrlSuspendBit];
  assign wake_ack_o    = ack_wr & (wb_adr_i == usb_aon_pkg::RegCtrl) &
                         wb_dat_i[usb_aon_pkg::CtrlWakeAckBit];
  assign clear_ovf_o   = ack_rd & (wb_adr_i == usb_aon_pkg::RegStatus);
  // The head leaves the FIFO at the end of the ack cycle
  assign evt_i.ready   = ack_rd & (wb_adr_i == usb_aon_pkg::RegEvent);

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

endmodule
